/* verilog/fsab_pkg.sv */
package fsab_pkg;

	// Request mode
	localparam int FSAB_MODE_W = 1;
	localparam logic [FSAB_MODE_W-1:0] FSAB_READ  = 1'b0;
	localparam logic [FSAB_MODE_W-1:0] FSAB_WRITE = 1'b1;

	// Field widths of a bus beat
	localparam int FSAB_DID_W  = 4;   // Device and sub-device ids
	localparam int FSAB_ADDR_W = 31;  // Byte address
	localparam int FSAB_LEN_W  = 4;   // Burst length, 1 to 8
	localparam int FSAB_DATA_W = 64;
	localparam int FSAB_MASK_W = FSAB_DATA_W / 8;  // 1 writes the byte

	// Burst and credit limits
	localparam int FSAB_LEN_MAX         = 8;
	localparam int FSAB_INITIAL_CREDITS = 4;  // Master starts with these

endpackage

/* verilog/mem_pkg.sv */
package mem_pkg;

	// Command port encoding
	localparam int MEM_CMD_W = 3;
	localparam logic [MEM_CMD_W-1:0] MEM_CMD_WRITE = 3'd0;
	localparam logic [MEM_CMD_W-1:0] MEM_CMD_READ  = 3'd1;

	localparam int MEM_BEAT_BYTES = 8;  // Address step per command

	// Reads allowed in flight toward the response side
	localparam int RESP_CREDITS = 4;

	// Queue sizes follow the bus credits
	localparam int HDR_DEPTH  = fsab_pkg::FSAB_INITIAL_CREDITS;
	localparam int BEAT_DEPTH = fsab_pkg::FSAB_INITIAL_CREDITS * fsab_pkg::FSAB_LEN_MAX;

endpackage

/* verilog/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clk0_tb,
	input  logic             rst0_tb,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] wr_data,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty,
	output logic             full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;   // Overflow is dropped
	assign do_pop  = pop && !empty;
	assign empty   = (count == '0);
	assign full    = (count == CNT_W'(DEPTH));
	assign rd_data = mem[rd_ptr];     // Head visible without a pop

	always_ff @(posedge clk0_tb) begin
		if (do_push)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

endmodule

/* verilog/req_queue.sv */
`timescale 1ns/100ps

module req_queue import fsab_pkg::*, mem_pkg::*; (
	input  logic                   clk0_tb,
	input  logic                   rst0_tb,
	input  logic                   fsabo_valid,
	input  logic [FSAB_MODE_W-1:0] fsabo_mode,
	input  logic [FSAB_DID_W-1:0]  fsabo_did,
	input  logic [FSAB_DID_W-1:0]  fsabo_subdid,
	input  logic [FSAB_ADDR_W-1:0] fsabo_addr,
	input  logic [FSAB_LEN_W-1:0]  fsabo_len,
	input  logic                   burst_active,
	input  logic                   req_done,
	input  logic                   hdr_pop,
	output logic                   req_ready,
	output logic [FSAB_MODE_W-1:0] hdr_mode,
	output logic [FSAB_DID_W-1:0]  hdr_did,
	output logic [FSAB_DID_W-1:0]  hdr_subdid,
	output logic [FSAB_ADDR_W-1:0] hdr_addr,
	output logic [FSAB_LEN_W-1:0]  hdr_len
);
	localparam int HDR_W = FSAB_MODE_W + 2 * FSAB_DID_W + FSAB_ADDR_W + FSAB_LEN_W;
	localparam int CNT_W = $clog2(HDR_DEPTH + 1);

	logic             hdr_push;
	logic [HDR_W-1:0] hdr_in;
	logic [HDR_W-1:0] hdr_out;
	logic [CNT_W-1:0] done_cnt;  // Requests with all beats received

	assign hdr_push  = fsabo_valid && !burst_active;  // First beat carries the header
	assign hdr_in    = {fsabo_mode, fsabo_did, fsabo_subdid, fsabo_addr, fsabo_len};
	assign {hdr_mode, hdr_did, hdr_subdid, hdr_addr, hdr_len} = hdr_out;
	assign req_ready = (done_cnt != '0);

	// A write is only counted once its last data beat is queued
	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb)
			done_cnt <= '0;
		else
			done_cnt <= done_cnt + CNT_W'(req_done) - CNT_W'(hdr_pop);
	end

	sync_fifo #(.WIDTH(HDR_W), .DEPTH(HDR_DEPTH)) u_hdr_fifo (
		.clk0_tb, .rst0_tb, .push(hdr_push), .pop(hdr_pop),
		.wr_data(hdr_in), .rd_data(hdr_out), .empty(), .full()
	);

endmodule

/* verilog/wdata_queue.sv */
`timescale 1ns/100ps

module wdata_queue import fsab_pkg::*, mem_pkg::*; (
	input  logic                   clk0_tb,
	input  logic                   rst0_tb,
	input  logic                   fsabo_valid,
	input  logic [FSAB_MODE_W-1:0] fsabo_mode,
	input  logic [FSAB_LEN_W-1:0]  fsabo_len,
	input  logic [FSAB_DATA_W-1:0] fsabo_data,
	input  logic [FSAB_MASK_W-1:0] fsabo_mask,
	input  logic                   beat_pop,
	output logic                   burst_active,
	output logic                   req_done,
	output logic [FSAB_DATA_W-1:0] beat_data,
	output logic [FSAB_MASK_W-1:0] beat_mask
);
	localparam int BEAT_W = FSAB_DATA_W + FSAB_MASK_W;

	logic [FSAB_LEN_W-1:0] beats_left;  // Write beats still to come
	logic                  new_req;
	logic                  beat_push;
	logic [BEAT_W-1:0]     beat_out;

	assign burst_active = (beats_left != '0);
	assign new_req      = fsabo_valid && !burst_active;
	assign beat_push    = fsabo_valid && (burst_active || fsabo_mode == FSAB_WRITE);

	// Reads end on their header, writes on the last data beat
	assign req_done = new_req ? (fsabo_mode == FSAB_READ || fsabo_len == 1) :
	                  (fsabo_valid && beats_left == 1);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb)
			beats_left <= '0;
		else if (new_req && fsabo_mode == FSAB_WRITE)
			beats_left <= fsabo_len - 1'b1;  // Header beat holds data too
		else if (fsabo_valid && burst_active)
			beats_left <= beats_left - 1'b1;
	end

	assign {beat_data, beat_mask} = beat_out;

	sync_fifo #(.WIDTH(BEAT_W), .DEPTH(BEAT_DEPTH)) u_beat_fifo (
		.clk0_tb, .rst0_tb, .push(beat_push), .pop(beat_pop),
		.wr_data({fsabo_data, fsabo_mask}), .rd_data(beat_out), .empty(), .full()
	);

endmodule

/* verilog/mem_sequencer.sv */
`timescale 1ns/100ps

module mem_sequencer import fsab_pkg::*, mem_pkg::*; (
	input  logic                   clk0_tb,
	input  logic                   rst0_tb,
	input  logic                   req_ready,
	input  logic [FSAB_MODE_W-1:0] hdr_mode,
	input  logic [FSAB_DID_W-1:0]  hdr_did,
	input  logic [FSAB_DID_W-1:0]  hdr_subdid,
	input  logic [FSAB_ADDR_W-1:0] hdr_addr,
	input  logic [FSAB_LEN_W-1:0]  hdr_len,
	input  logic [FSAB_DATA_W-1:0] beat_data,
	input  logic [FSAB_MASK_W-1:0] beat_mask,
	input  logic                   resp_done,
	input  logic                   mem_cmd_afull,
	input  logic                   mem_wdf_afull,
	input  logic                   mem_init_done,
	output logic                   hdr_pop,
	output logic                   beat_pop,
	output logic                   tag_push,
	output logic [FSAB_DID_W-1:0]  tag_did,
	output logic [FSAB_DID_W-1:0]  tag_subdid,
	output logic [FSAB_LEN_W-1:0]  tag_len,
	output logic                   fsabo_credit,
	output logic                   mem_cmd_wren,
	output logic [MEM_CMD_W-1:0]   mem_cmd,
	output logic [FSAB_ADDR_W-1:0] mem_addr,
	output logic                   mem_wdf_wren,
	output logic [FSAB_DATA_W-1:0] mem_wdf_data,
	output logic [FSAB_MASK_W-1:0] mem_wdf_mask
);
	localparam int RC_W = $clog2(RESP_CREDITS + 1);

	logic                   active;      // Request popped, commands pending
	logic [FSAB_MODE_W-1:0] cur_mode;
	logic [FSAB_ADDR_W-1:0] cur_addr;
	logic [FSAB_LEN_W-1:0]  beats_left;
	logic [RC_W-1:0]        resp_credits;
	logic                   is_write;
	logic                   issue;

	// A read takes its response credit when it leaves the header queue
	assign hdr_pop  = !active && req_ready &&
	                  (hdr_mode == FSAB_WRITE || (resp_credits != '0 && mem_init_done));
	assign tag_push = hdr_pop && (hdr_mode == FSAB_READ);
	assign tag_did    = hdr_did;
	assign tag_subdid = hdr_subdid;
	assign tag_len    = hdr_len;

	assign is_write = (cur_mode == FSAB_WRITE);
	assign issue    = active && !mem_cmd_afull && !(is_write && mem_wdf_afull);

	assign mem_cmd_wren = issue;
	assign mem_cmd      = is_write ? MEM_CMD_WRITE : MEM_CMD_READ;
	assign mem_addr     = cur_addr;
	assign mem_wdf_wren = issue && is_write;  // Data goes with its command
	assign mem_wdf_data = beat_data;
	assign mem_wdf_mask = beat_mask;           // Same polarity as the bus
	assign beat_pop     = mem_wdf_wren;
	assign fsabo_credit = issue && (beats_left == 1);  // Last command of the request

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			active     <= 1'b0;
			beats_left <= '0;
		end else if (hdr_pop) begin
			active     <= 1'b1;
			beats_left <= hdr_len;
		end else if (issue) begin
			active     <= (beats_left != 1);
			beats_left <= beats_left - 1'b1;
		end
	end

	// Held under back-pressure, so a stalled command is retried unchanged
	always_ff @(posedge clk0_tb) begin
		if (hdr_pop) begin
			cur_mode <= hdr_mode;
			cur_addr <= hdr_addr;
		end else if (issue)
			cur_addr <= cur_addr + FSAB_ADDR_W'(MEM_BEAT_BYTES);
	end

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb)
			resp_credits <= RC_W'(RESP_CREDITS);
		else if (tag_push && !resp_done)
			resp_credits <= resp_credits - 1'b1;
		else if (resp_done && !tag_push)
			resp_credits <= resp_credits + 1'b1;
	end

endmodule

/* verilog/read_return.sv */
`timescale 1ns/100ps

module read_return import fsab_pkg::*, mem_pkg::*; (
	input  logic                   clk0_tb,
	input  logic                   rst0_tb,
	input  logic                   tag_push,
	input  logic [FSAB_DID_W-1:0]  tag_did,
	input  logic [FSAB_DID_W-1:0]  tag_subdid,
	input  logic [FSAB_LEN_W-1:0]  tag_len,
	input  logic                   mem_rd_valid,
	input  logic [FSAB_DATA_W-1:0] mem_rd_data,
	output logic                   resp_done,
	output logic                   fsabi_valid,
	output logic [FSAB_DID_W-1:0]  fsabi_did,
	output logic [FSAB_DID_W-1:0]  fsabi_subdid,
	output logic [FSAB_DATA_W-1:0] fsabi_data
);
	localparam int TAG_W = 2 * FSAB_DID_W + FSAB_LEN_W;

	logic [TAG_W-1:0]       tag_out;
	logic [FSAB_DID_W-1:0]  head_did;
	logic [FSAB_DID_W-1:0]  head_subdid;
	logic [FSAB_LEN_W-1:0]  head_len;
	logic [FSAB_LEN_W-1:0]  beats_left;  // Beats still owed to the current burst
	logic [FSAB_DATA_W-1:0] data_head;
	logic                   tag_empty;
	logic                   data_empty;
	logic                   beat_go;
	logic                   tag_pop;
	logic                   last_beat;

	assign {head_did, head_subdid, head_len} = tag_out;
	assign beat_go   = !data_empty && (beats_left != '0 || !tag_empty);
	assign tag_pop   = beat_go && (beats_left == '0);  // New burst starts
	assign last_beat = tag_pop ? (head_len == 1) : (beats_left == 1);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			beats_left  <= '0;
			fsabi_valid <= 1'b0;
			resp_done   <= 1'b0;
		end else begin
			fsabi_valid <= beat_go;
			resp_done   <= beat_go && last_beat;  // Frees a response credit
			if (tag_pop)
				beats_left <= head_len - 1'b1;
			else if (beat_go)
				beats_left <= beats_left - 1'b1;
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (beat_go)
			fsabi_data <= data_head;
		if (tag_pop) begin
			fsabi_did    <= head_did;
			fsabi_subdid <= head_subdid;
		end
	end

	sync_fifo #(.WIDTH(TAG_W), .DEPTH(HDR_DEPTH)) u_tag_fifo (
		.clk0_tb, .rst0_tb, .push(tag_push), .pop(tag_pop),
		.wr_data({tag_did, tag_subdid, tag_len}), .rd_data(tag_out),
		.empty(tag_empty), .full()
	);

	sync_fifo #(.WIDTH(FSAB_DATA_W), .DEPTH(BEAT_DEPTH)) u_data_fifo (
		.clk0_tb, .rst0_tb, .push(mem_rd_valid), .pop(beat_go),
		.wr_data(mem_rd_data), .rd_data(data_head), .empty(data_empty), .full()
	);

endmodule

/* verilog/fsab_mem_bridge.sv */
`timescale 1ns/100ps

module fsab_mem_bridge import fsab_pkg::*, mem_pkg::*; (
	input  logic                   clk0_tb,
	input  logic                   rst0_tb,
	input  logic                   fsabo_valid,   // Bus request side
	input  logic [FSAB_MODE_W-1:0] fsabo_mode,
	input  logic [FSAB_DID_W-1:0]  fsabo_did,
	input  logic [FSAB_DID_W-1:0]  fsabo_subdid,
	input  logic [FSAB_ADDR_W-1:0] fsabo_addr,
	input  logic [FSAB_LEN_W-1:0]  fsabo_len,
	input  logic [FSAB_DATA_W-1:0] fsabo_data,
	input  logic [FSAB_MASK_W-1:0] fsabo_mask,
	output logic                   fsabo_credit,
	output logic                   mem_cmd_wren,  // Memory controller side
	output logic [MEM_CMD_W-1:0]   mem_cmd,
	output logic [FSAB_ADDR_W-1:0] mem_addr,
	output logic                   mem_wdf_wren,
	output logic [FSAB_DATA_W-1:0] mem_wdf_data,
	output logic [FSAB_MASK_W-1:0] mem_wdf_mask,
	input  logic                   mem_cmd_afull,
	input  logic                   mem_wdf_afull,
	input  logic                   mem_rd_valid,
	input  logic [FSAB_DATA_W-1:0] mem_rd_data,
	input  logic                   mem_init_done,
	output logic                   fsabi_valid,   // Bus response side
	output logic [FSAB_DID_W-1:0]  fsabi_did,
	output logic [FSAB_DID_W-1:0]  fsabi_subdid,
	output logic [FSAB_DATA_W-1:0] fsabi_data
);
	logic                   burst_active, req_done, req_ready, hdr_pop;
	logic [FSAB_MODE_W-1:0] hdr_mode;
	logic [FSAB_DID_W-1:0]  hdr_did, hdr_subdid;
	logic [FSAB_ADDR_W-1:0] hdr_addr;
	logic [FSAB_LEN_W-1:0]  hdr_len;
	logic                   beat_pop;
	logic [FSAB_DATA_W-1:0] beat_data;
	logic [FSAB_MASK_W-1:0] beat_mask;
	logic                   tag_push, resp_done;
	logic [FSAB_DID_W-1:0]  tag_did, tag_subdid;
	logic [FSAB_LEN_W-1:0]  tag_len;

	// Port names match the nets, so the blocks connect by name
	req_queue     u_req_queue     (.*);
	wdata_queue   u_wdata_queue   (.*);
	mem_sequencer u_mem_sequencer (.*);
	read_return   u_read_return   (.*);

endmodule

/* tb/fsab_mem_props.sv */
`timescale 1ns/100ps

module fsab_mem_props import mem_pkg::*; (
	input logic                 clk0_tb,
	input logic                 rst0_tb,
	input logic                 fsabo_credit,
	input logic                 mem_cmd_wren,
	input logic [MEM_CMD_W-1:0] mem_cmd,
	input logic                 mem_cmd_afull,
	input logic                 mem_wdf_wren,
	input logic                 fsabi_valid
);
	int fail_count = 0;  // Polled by the testbench

	a_cmd_afull: assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		!(mem_cmd_wren && mem_cmd_afull))
		else begin
			$error("mem_cmd_wren asserted while mem_cmd_afull is high");
			fail_count++;
		end

	// Write data only travels with its write command
	a_wdf_with_cmd: assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		mem_wdf_wren |-> (mem_cmd_wren && mem_cmd == MEM_CMD_WRITE))
		else begin
			$error("mem_wdf_wren without a write command");
			fail_count++;
		end

	a_reset_quiet: assert property (@(posedge clk0_tb)
		rst0_tb |-> !(fsabo_credit || mem_cmd_wren || fsabi_valid))
		else begin
			$error("Output strobe active during reset");
			fail_count++;
		end

endmodule

bind fsab_mem_bridge fsab_mem_props u_props (.*);

/* tb/fsab_mem_tb.sv */
`timescale 1ns/100ps

module fsab_mem_tb import fsab_pkg::*, mem_pkg::*; ();
	localparam int TIMEOUT_CYCLES = 4000;  // About four times the test length

	logic                   clk0_tb;
	logic                   rst0_tb;
	logic                   fsabo_valid;
	logic [FSAB_MODE_W-1:0] fsabo_mode;
	logic [FSAB_DID_W-1:0]  fsabo_did;
	logic [FSAB_DID_W-1:0]  fsabo_subdid;
	logic [FSAB_ADDR_W-1:0] fsabo_addr;
	logic [FSAB_LEN_W-1:0]  fsabo_len;
	logic [FSAB_DATA_W-1:0] fsabo_data;
	logic [FSAB_MASK_W-1:0] fsabo_mask;
	logic                   fsabo_credit;
	logic                   mem_cmd_wren;
	logic [MEM_CMD_W-1:0]   mem_cmd;
	logic [FSAB_ADDR_W-1:0] mem_addr;
	logic                   mem_wdf_wren;
	logic [FSAB_DATA_W-1:0] mem_wdf_data;
	logic [FSAB_MASK_W-1:0] mem_wdf_mask;
	logic                   mem_cmd_afull;
	logic                   mem_wdf_afull;
	logic                   mem_rd_valid;
	logic [FSAB_DATA_W-1:0] mem_rd_data;
	logic                   mem_init_done;
	logic                   fsabi_valid;
	logic [FSAB_DID_W-1:0]  fsabi_did;
	logic [FSAB_DID_W-1:0]  fsabi_subdid;
	logic [FSAB_DATA_W-1:0] fsabi_data;

	logic [FSAB_DATA_W-1:0] mem_model [int];  // Written by DUT commands
	logic [FSAB_DATA_W-1:0] exp_mem [int];    // Written by the stimulus
	logic [FSAB_DATA_W-1:0] rd_data_q [$];
	int                     rd_due [$];
	logic [FSAB_DATA_W-1:0] exp_data [$];     // One entry per response beat
	logic [FSAB_DID_W-1:0]  exp_did [$];
	logic [FSAB_DID_W-1:0]  exp_subdid [$];
	int credits = FSAB_INITIAL_CREDITS;
	int exp_cmds = 0;  // One memory command per beat sent
	int cmd_count = 0;
	int model_cycle = 0;
	int cycle = 0;

	fsab_mem_bridge DUT (.*);

	initial begin
		clk0_tb = 1'b0;
		forever #10 clk0_tb = ~clk0_tb;
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [FSAB_DATA_W-1:0] exp,
			input logic [FSAB_DATA_W-1:0] act);
		if (act !== exp) begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
			abort_run("Data mismatch");
		end
	endtask

	task automatic check_id(input string name, input logic [FSAB_DID_W-1:0] exp,
			input logic [FSAB_DID_W-1:0] act);
		if (act !== exp) begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
			abort_run("Id mismatch");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			abort_run("Count mismatch");
		end
	endtask

	// Unwritten memory reads back a word made from its beat index
	function automatic logic [FSAB_DATA_W-1:0] fill_word(input int idx);
		return {32'(idx) ^ 32'h96c3_a50f, ~32'(idx)};
	endfunction

	function automatic logic [FSAB_DATA_W-1:0] merge_bytes(input logic [FSAB_DATA_W-1:0] old_w,
			input logic [FSAB_DATA_W-1:0] new_w, input logic [FSAB_MASK_W-1:0] mask);
		logic [FSAB_DATA_W-1:0] res;
		res = old_w;
		for (int b = 0; b < FSAB_MASK_W; b++)
			if (mask[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		return res;
	endfunction

	function automatic logic [FSAB_DATA_W-1:0] mem_word(input int idx);
		return mem_model.exists(idx) ? mem_model[idx] : fill_word(idx);
	endfunction

	function automatic logic [FSAB_DATA_W-1:0] exp_word(input int idx);
		return exp_mem.exists(idx) ? exp_mem[idx] : fill_word(idx);
	endfunction

	// Memory behind the controller ports, reads return in command order
	always @(posedge clk0_tb) begin
		int idx;
		int due;
		model_cycle++;
		idx = int'(mem_addr / MEM_BEAT_BYTES);
		if (mem_cmd_wren) begin
			cmd_count++;
			if (mem_cmd == MEM_CMD_WRITE) begin
				if (mem_wdf_wren !== 1'b1)
					abort_run("Write command issued without mem_wdf_wren");
				else
					mem_model[idx] = merge_bytes(mem_word(idx), mem_wdf_data, mem_wdf_mask);
			end else begin
				due = model_cycle + 1 + int'($urandom % 4);  // 1 to 4 cycles
				if (rd_due.size() != 0 && due <= rd_due[$])
					due = rd_due[$] + 1;
				rd_due.push_back(due);
				rd_data_q.push_back(mem_word(idx));
			end
		end
		#2;
		if (rd_due.size() != 0 && rd_due[0] <= model_cycle) begin
			mem_rd_valid = 1'b1;
			mem_rd_data  = rd_data_q.pop_front();
			void'(rd_due.pop_front());
		end else
			mem_rd_valid = 1'b0;
	end

	always @(posedge clk0_tb) begin
		if (!rst0_tb && fsabo_credit) begin
			credits++;
			if (!mem_cmd_wren)
				abort_run("fsabo_credit pulsed without a memory command");
			else if (credits > FSAB_INITIAL_CREDITS)
				abort_run("fsabo_credit returned with no request outstanding");
		end
	end

	// Each response beat is compared with the oldest expected beat
	always @(posedge clk0_tb) begin
		if (!rst0_tb && fsabi_valid) begin
			if (exp_data.size() == 0)
				abort_run("Response beat arrived with no read outstanding");
			else begin
				check_data("fsabi_data", exp_data.pop_front(), fsabi_data);
				check_id("fsabi_did", exp_did.pop_front(), fsabi_did);
				check_id("fsabi_subdid", exp_subdid.pop_front(), fsabi_subdid);
			end
		end
	end

	always @(posedge clk0_tb) begin
		cycle++;
		if (cycle >= TIMEOUT_CYCLES)
			abort_run("Timeout: the tests did not finish in time");
		else if (DUT.u_props.fail_count != 0)
			abort_run("A bound assertion on the DUT ports failed");
	end

	task automatic next_cycle();
		@(posedge clk0_tb);
		#2;
	endtask

	task automatic take_credit();
		while (credits == 0)
			next_cycle();
		credits--;
	endtask

	task automatic send_write(input logic [FSAB_DID_W-1:0] did,
			input logic [FSAB_DID_W-1:0] subdid, input logic [FSAB_ADDR_W-1:0] addr,
			input int len, input bit rand_mask);
		logic [FSAB_DATA_W-1:0] data;
		logic [FSAB_MASK_W-1:0] mask;
		int idx;
		take_credit();
		exp_cmds += len;
		for (int i = 0; i < len; i++) begin
			data = {$urandom, $urandom};
			mask = rand_mask ? FSAB_MASK_W'($urandom) : '1;
			idx = int'(addr / MEM_BEAT_BYTES) + i;
			exp_mem[idx] = merge_bytes(exp_word(idx), data, mask);
			fsabo_valid  = 1'b1;
			fsabo_mode   = FSAB_WRITE;
			fsabo_did    = did;
			fsabo_subdid = subdid;
			fsabo_addr   = addr;
			fsabo_len    = FSAB_LEN_W'(len);
			fsabo_data   = data;
			fsabo_mask   = mask;
			next_cycle();
		end
		fsabo_valid = 1'b0;
	endtask

	task automatic send_read(input logic [FSAB_DID_W-1:0] did,
			input logic [FSAB_DID_W-1:0] subdid, input logic [FSAB_ADDR_W-1:0] addr,
			input int len);
		take_credit();
		exp_cmds += len;
		for (int i = 0; i < len; i++) begin
			exp_data.push_back(exp_word(int'(addr / MEM_BEAT_BYTES) + i));
			exp_did.push_back(did);
			exp_subdid.push_back(subdid);
		end
		fsabo_valid  = 1'b1;
		fsabo_mode   = FSAB_READ;
		fsabo_did    = did;
		fsabo_subdid = subdid;
		fsabo_addr   = addr;
		fsabo_len    = FSAB_LEN_W'(len);
		next_cycle();
		fsabo_valid = 1'b0;
	endtask

	// All commands issued and all response beats seen
	task automatic wait_drain();
		while (exp_data.size() != 0 || cmd_count != exp_cmds)
			next_cycle();
		check_count("credit balance", FSAB_INITIAL_CREDITS, credits);
	endtask

	task automatic test_idle_after_reset();
		for (int i = 0; i < 5; i++) begin
			if (i == 3)
				mem_init_done = 1'b1;  // Controller calibration done
			check_count("fsabo_credit", 0, int'(fsabo_credit !== 1'b0));
			check_count("mem_cmd_wren", 0, int'(mem_cmd_wren !== 1'b0));
			check_count("fsabi_valid", 0, int'(fsabi_valid !== 1'b0));
			next_cycle();
		end
	endtask

	task automatic test_single_write_read();
		send_write(4'h2, 4'h7, 31'h100, 1, 1'b0);
		send_read(4'h5, 4'h3, 31'h100, 1);
		wait_drain();
	endtask

	task automatic test_burst_masked();
		send_write(4'h1, 4'h1, 31'h200, 8, 1'b1);
		send_read(4'h6, 4'h2, 31'h200, 8);
		wait_drain();
	endtask

	task automatic test_read_order();
		for (int i = 0; i < 4; i++)
			send_read(FSAB_DID_W'(8 + i), FSAB_DID_W'(i), FSAB_ADDR_W'(32'h200 + 8 * i), i + 1);
		wait_drain();
	endtask

	task automatic test_credit_count();
		int n;
		n = 12;
		for (int i = 0; i < n; i++) begin
			if ($urandom % 2)
				send_write(FSAB_DID_W'(i), 4'h4, FSAB_ADDR_W'(($urandom % 64) * 8),
					1 + int'($urandom % 8), 1'b1);
			else
				send_read(FSAB_DID_W'(i), 4'h9, FSAB_ADDR_W'(($urandom % 64) * 8),
					1 + int'($urandom % 8));
		end
		wait_drain();
	endtask

	task automatic test_cmd_backpressure();
		int n0;
		n0 = cmd_count;
		send_write(4'h3, 4'h5, 31'h400, 8, 1'b1);
		while (cmd_count == n0)
			next_cycle();
		mem_cmd_afull = 1'b1;  // Stall the rest of the burst
		n0 = cmd_count;
		repeat (20) next_cycle();
		check_count("commands under mem_cmd_afull", n0, cmd_count);
		mem_cmd_afull = 1'b0;
		send_read(4'hc, 4'h5, 31'h400, 8);
		wait_drain();
	endtask

	initial begin
		void'($urandom(32'hdc83f76f));
		rst0_tb       = 1'b1;
		fsabo_valid   = 1'b0;
		fsabo_mode    = FSAB_READ;
		fsabo_did     = '0;
		fsabo_subdid  = '0;
		fsabo_addr    = '0;
		fsabo_len     = '0;
		fsabo_data    = '0;
		fsabo_mask    = '0;
		mem_cmd_afull = 1'b0;
		mem_wdf_afull = 1'b0;
		mem_rd_valid  = 1'b0;
		mem_rd_data   = '0;
		mem_init_done = 1'b0;
		repeat (4) @(posedge clk0_tb);
		#2 rst0_tb = 1'b0;
		test_idle_after_reset();
		test_single_write_read();
		test_burst_masked();
		test_read_order();
		test_credit_count();
		test_cmd_backpressure();
		if (DUT.u_props.fail_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else
			abort_run("A bound assertion on the DUT ports failed");
	end

endmodule

/* fsab_mem.f */
verilog/fsab_pkg.sv
verilog/mem_pkg.sv
verilog/sync_fifo.sv
verilog/req_queue.sv
verilog/wdata_queue.sv
verilog/mem_sequencer.sv
verilog/read_return.sv
verilog/fsab_mem_bridge.sv
tb/fsab_mem_props.sv
tb/fsab_mem_tb.sv

/* Bender.yml */
package:
  name: fsab_mem

sources:
  - verilog/fsab_pkg.sv
  - verilog/mem_pkg.sv
  - verilog/sync_fifo.sv
  - verilog/req_queue.sv
  - verilog/wdata_queue.sv
  - verilog/mem_sequencer.sv
  - verilog/read_return.sv
  - verilog/fsab_mem_bridge.sv
  - target: test
    files:
      - tb/fsab_mem_props.sv
      - tb/fsab_mem_tb.sv
